//--- files.f
source/phold_pkg.sv
source/lfsr.sv
source/rr_arbiter.sv
source/event_queue.sv
source/phold_core.sv
source/gvt_tracker.sv
source/phold_ctrl.sv
source/phold_top.sv
tb/tb_clock.sv
tb/phold_assert.sv
tb/phold_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= phold_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test FAILED, see $(LOG)"; exit 1; \
	else \
		echo "test ok"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/phold_tb.sv
`timescale 1ns/1ps

module phold_tb;
   import phold_pkg::*;

   localparam logic [TIME_WID-1:0] SIM_END = 16'd200;
   localparam logic [7:0] NUM_INIT = 8'd12;
   localparam logic [7:0] LP_MASK = 8'h3f;
   // about 25 events per time unit over 200 units, margin of 4
   localparam int TIMEOUT_CYCLES = 25 * 200 * 4;
   localparam int RST_CYCLES = 10;
   localparam int DRAIN_CYCLES = 20;

   logic                clk;
   logic                rst_n;
   logic [TIME_WID-1:0] sim_end;
   logic [7:0]          num_init_events;
   logic [7:0]          lp_mask;
   logic [TIME_WID-1:0] gvt;
   logic                rtn_vld;
   logic [CNT_WID-1:0]  total_cycles;
   logic [CNT_WID-1:0]  total_events;
   logic                ev_sent;
   logic [LP_WID-1:0]   ev_sent_lp;
   logic [TIME_WID-1:0] ev_sent_time;

   int sent_cnt = 0;
   int rtn_cnt = 0;
   int cycle_cnt = 0;
   bit fail_reported = 1'b0;
   bit pass_done = 1'b0;

   tb_clock u_clk (.clk(clk));

   phold_top DUT (
      .clk(clk), .rst_n(rst_n), .sim_end(sim_end),
      .num_init_events(num_init_events), .lp_mask(lp_mask),
      .gvt(gvt), .rtn_vld(rtn_vld),
      .total_cycles(total_cycles), .total_events(total_events),
      .ev_sent(ev_sent), .ev_sent_lp(ev_sent_lp), .ev_sent_time(ev_sent_time)
   );

   task automatic abort_run(input string msg);
      fail_reported = 1'b1;
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run stopped at the first error");
   endtask

   // init event i targets LP i under the mask, queued in index order
   function automatic logic [LP_WID-1:0] init_lp(input int idx);
      return LP_WID'(idx) & LP_MASK[LP_WID-1:0];
   endfunction

   // end-of-run values at the finish pulse
   task automatic check_finish();
      if (gvt <= SIM_END) begin
         abort_run($sformatf("Mismatch gvt: got 0x%h expected above 0x%h", gvt, SIM_END));
      end
      if (total_events != CNT_WID'(sent_cnt)) begin
         abort_run($sformatf("Mismatch total_events: got 0x%h expected 0x%h",
                             total_events, CNT_WID'(sent_cnt)));
      end
      if (total_cycles == '0) begin
         abort_run($sformatf("Mismatch total_cycles: got 0x%h expected nonzero", total_cycles));
      end
   endtask

   // outputs are sampled mid-cycle
   always @(negedge clk) begin
      if (DUT.u_chk.fail_cnt != 0) begin
         abort_run("a bound assertion failed");
      end
      if (rst_n) begin
         cycle_cnt = cycle_cnt + 1;
         if (cycle_cnt >= TIMEOUT_CYCLES && rtn_cnt == 0) begin
            abort_run($sformatf("timeout: rtn_vld never arrived within %0d cycles",
                                TIMEOUT_CYCLES));
         end
         if (ev_sent) begin
            // init events are the only ones at time zero
            if (sent_cnt < int'(NUM_INIT) && ev_sent_time != '0) begin
               abort_run($sformatf("Mismatch ev_sent_time: got 0x%h expected 0x%h",
                                   ev_sent_time, 16'h0000));
            end
            if (sent_cnt < int'(NUM_INIT) && ev_sent_lp != init_lp(sent_cnt)) begin
               abort_run($sformatf("Mismatch ev_sent_lp: got 0x%h expected 0x%h",
                                   ev_sent_lp, init_lp(sent_cnt)));
            end
            if (sent_cnt >= int'(NUM_INIT) && ev_sent_time == '0) begin
               abort_run($sformatf("Mismatch ev_sent_time: got 0x%h expected at least 0x%h",
                                   ev_sent_time, 16'h0001));
            end
            sent_cnt = sent_cnt + 1;
         end
         if (rtn_vld) begin
            rtn_cnt = rtn_cnt + 1;
            check_finish();
         end
      end
   end

   // run ended by the simulator before any verdict
   final begin
      if (!pass_done && !fail_reported) begin
         $display("Simulation failed");
      end
   end

   initial begin
      rst_n = 1'b0;
      sim_end = SIM_END;
      num_init_events = NUM_INIT;
      lp_mask = LP_MASK;
      repeat (RST_CYCLES) @(posedge clk);
      #2;
      rst_n = 1'b1;
      while (rtn_cnt == 0) begin
         @(negedge clk);
      end
      // let the post-finish assertions run for a while
      repeat (DRAIN_CYCLES) @(negedge clk);
      #1;
      if (rtn_cnt != 1) begin
         abort_run($sformatf("Mismatch rtn_vld pulse count: got 0x%h expected 0x%h",
                             rtn_cnt, 1));
      end else if (DUT.u_chk.fail_cnt != 0) begin
         abort_run("a bound assertion failed near the end of the run");
      end else begin
         pass_done = 1'b1;
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

//--- tb/phold_assert.sv
`timescale 1ns/1ps

module phold_assert (
   input logic                           clk,
   input logic                           rst_n,
   input logic [phold_pkg::TIME_WID-1:0] sim_end,
   input logic [7:0]                     lp_mask,
   input logic                           running,
   input logic [phold_pkg::TIME_WID-1:0] gvt,
   input logic                           rtn_vld,
   input logic [phold_pkg::CNT_WID-1:0]  total_cycles,
   input logic [phold_pkg::CNT_WID-1:0]  total_events,
   input logic                           ev_sent,
   input logic [phold_pkg::LP_WID-1:0]   ev_sent_lp,
   input logic [phold_pkg::TIME_WID-1:0] ev_sent_time
);
   import phold_pkg::*;

   int   fail_cnt = 0;
   logic started;
   logic rtn_seen;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         started <= 1'b0;
         rtn_seen <= 1'b0;
      end else begin
         if (running) begin
            started <= 1'b1;
         end
         if (rtn_vld) begin
            rtn_seen <= 1'b1;
         end
      end
   end

   // outputs quiet until the first running cycle
   assert property (@(posedge clk) disable iff (!rst_n)
      !started |-> (!rtn_vld && !ev_sent && gvt == '0 &&
                    total_cycles == '0 && total_events == '0))
   else begin
      fail_cnt = fail_cnt + 1;
      $error("outputs active before the run started");
   end

   assert property (@(posedge clk) disable iff (!rst_n) gvt >= $past(gvt))
   else begin
      fail_cnt = fail_cnt + 1;
      $error("gvt decreased to 0x%h", gvt);
   end

   assert property (@(posedge clk) disable iff (!rst_n) ev_sent |-> ev_sent_time >= gvt)
   else begin
      fail_cnt = fail_cnt + 1;
      $error("dispatched time 0x%h below gvt 0x%h", ev_sent_time, gvt);
   end

   assert property (@(posedge clk) disable iff (!rst_n)
      ev_sent |-> (ev_sent_lp & ~lp_mask[LP_WID-1:0]) == '0)
   else begin
      fail_cnt = fail_cnt + 1;
      $error("dispatched LP 0x%h outside mask 0x%h", ev_sent_lp, lp_mask);
   end

   assert property (@(posedge clk) disable iff (!rst_n) rtn_vld |-> gvt > sim_end)
   else begin
      fail_cnt = fail_cnt + 1;
      $error("rtn_vld with gvt 0x%h not past sim_end", gvt);
   end

   // nothing moves after the finish pulse
   assert property (@(posedge clk) disable iff (!rst_n) rtn_seen |-> (!rtn_vld && !ev_sent))
   else begin
      fail_cnt = fail_cnt + 1;
      $error("activity after the finish pulse");
   end

endmodule

bind phold_top phold_assert u_chk (
   .clk(clk),
   .rst_n(rst_n),
   .sim_end(sim_end),
   .lp_mask(lp_mask),
   .running(running),
   .gvt(gvt),
   .rtn_vld(rtn_vld),
   .total_cycles(total_cycles),
   .total_events(total_events),
   .ev_sent(ev_sent),
   .ev_sent_lp(ev_sent_lp),
   .ev_sent_time(ev_sent_time)
);

//--- tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
   parameter int HALF_NS = 10
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // 20 ns period
   always #(HALF_NS) clk = ~clk;

endmodule

//--- source/phold_top.sv
`timescale 1ns/1ps

module phold_top #(
   parameter int NUM_CORE = phold_pkg::DEF_NUM_CORE,
   parameter int QUEUE_DEPTH = phold_pkg::DEF_QUEUE_DEPTH
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [phold_pkg::TIME_WID-1:0] sim_end,
   input  logic [7:0]                     num_init_events,
   input  logic [7:0]                     lp_mask,
   output logic [phold_pkg::TIME_WID-1:0] gvt,
   output logic                           rtn_vld,
   output logic [phold_pkg::CNT_WID-1:0]  total_cycles,
   output logic [phold_pkg::CNT_WID-1:0]  total_events,
   output logic                           ev_sent,
   output logic [phold_pkg::LP_WID-1:0]   ev_sent_lp,
   output logic [phold_pkg::TIME_WID-1:0] ev_sent_time
);
   import phold_pkg::*;

   logic                    enq;
   logic                    deq;
   logic [LP_WID-1:0]       enq_lp;
   logic [TIME_WID-1:0]     enq_time;
   logic [LP_WID-1:0]       head_lp;
   logic [TIME_WID-1:0]     head_time;
   logic                    q_full;
   logic                    q_empty;
   logic [NUM_CORE-1:0]     rcv_req;
   logic [NUM_CORE-1:0]     rcv_gnt;
   logic                    rcv_gnt_vld;
   logic [NUM_CORE-1:0]     send_req;
   logic [NUM_CORE-1:0]     send_gnt;
   logic                    send_gnt_vld;
   logic [NUM_CORE-1:0]     ack;
   logic [NUM_CORE-1:0]     ev_valid;
   logic [NUM_CORE-1:0]     core_busy;
   logic [NUM_CORE*TIME_WID-1:0] core_time;
   logic [LP_WID-1:0]       core_new_lp [NUM_CORE];
   logic [TIME_WID-1:0]     core_new_time [NUM_CORE];
   logic [LP_WID-1:0]       new_lp;
   logic [TIME_WID-1:0]     new_time;
   logic [RND_WID-1:0]      rnd;
   logic                    next_rnd;
   logic                    running;

   // pick the event of the core that won the receive arbiter
   always_comb begin
      new_lp = '0;
      new_time = '0;
      for (int i = 0; i < NUM_CORE; i++) begin
         if (rcv_gnt[i]) begin
            new_lp = core_new_lp[i];
            new_time = core_new_time[i];
         end
      end
   end

   phold_ctrl #(.NUM_CORE(NUM_CORE)) u_ctrl (
      .clk(clk), .rst_n(rst_n), .sim_end(sim_end),
      .num_init_events(num_init_events), .lp_mask(lp_mask), .gvt(gvt),
      .q_full(q_full), .q_empty(q_empty),
      .rcv_gnt_vld(rcv_gnt_vld), .send_gnt_vld(send_gnt_vld),
      .rcv_gnt(rcv_gnt), .send_gnt(send_gnt),
      .new_lp(new_lp), .new_time(new_time),
      .head_lp(head_lp), .head_time(head_time),
      .enq(enq), .deq(deq), .enq_lp(enq_lp), .enq_time(enq_time),
      .ack(ack), .ev_valid(ev_valid), .next_rnd(next_rnd), .running(running),
      .rtn_vld(rtn_vld), .total_cycles(total_cycles), .total_events(total_events),
      .ev_sent(ev_sent), .ev_sent_lp(ev_sent_lp), .ev_sent_time(ev_sent_time)
   );

   event_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
      .clk(clk), .rst_n(rst_n), .enq(enq), .deq(deq),
      .in_lp(enq_lp), .in_time(enq_time),
      .head_lp(head_lp), .head_time(head_time), .full(q_full), .empty(q_empty)
   );

   // new events coming back from the cores
   rr_arbiter #(.NUM_CORE(NUM_CORE)) rcv_arb (
      .clk(clk), .rst_n(rst_n), .req(rcv_req), .gnt(rcv_gnt), .gnt_vld(rcv_gnt_vld)
   );

   // idle cores waiting for work
   rr_arbiter #(.NUM_CORE(NUM_CORE)) send_arb (
      .clk(clk), .rst_n(rst_n), .req(send_req), .gnt(send_gnt), .gnt_vld(send_gnt_vld)
   );

   lfsr #(.SEED(LFSR_SEED)) u_lfsr (
      .clk(clk), .rst_n(rst_n), .next(next_rnd), .rnd(rnd)
   );

   gvt_tracker #(.NUM_CORE(NUM_CORE)) u_gvt (
      .clk(clk), .rst_n(rst_n), .running(running),
      .head_time(head_time), .q_empty(q_empty),
      .core_busy(core_busy), .core_time(core_time), .gvt(gvt)
   );

   for (genvar g = 0; g < NUM_CORE; g++) begin : gen_core
      phold_core u_core (
         .clk(clk), .rst_n(rst_n), .ev_valid(ev_valid[g]), .ack(ack[g]),
         .ev_lp(head_lp), .ev_time(head_time), .rnd(rnd),
         .lp_mask(lp_mask[LP_WID-1:0]),
         .ready(send_req[g]), .new_ready(rcv_req[g]), .busy(core_busy[g]),
         .busy_time(core_time[g*TIME_WID +: TIME_WID]),
         .new_time(core_new_time[g]), .new_lp(core_new_lp[g])
      );
   end

endmodule

//--- source/phold_ctrl.sv
`timescale 1ns/1ps

module phold_ctrl #(
   parameter int NUM_CORE = 4
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [phold_pkg::TIME_WID-1:0] sim_end,
   input  logic [7:0]                     num_init_events,
   input  logic [7:0]                     lp_mask,
   input  logic [phold_pkg::TIME_WID-1:0] gvt,
   input  logic                           q_full,
   input  logic                           q_empty,
   input  logic                           rcv_gnt_vld,
   input  logic                           send_gnt_vld,
   input  logic [NUM_CORE-1:0]            rcv_gnt,
   input  logic [NUM_CORE-1:0]            send_gnt,
   input  logic [phold_pkg::LP_WID-1:0]   new_lp,
   input  logic [phold_pkg::TIME_WID-1:0] new_time,
   input  logic [phold_pkg::LP_WID-1:0]   head_lp,
   input  logic [phold_pkg::TIME_WID-1:0] head_time,
   output logic                           enq,
   output logic                           deq,
   output logic [phold_pkg::LP_WID-1:0]   enq_lp,
   output logic [phold_pkg::TIME_WID-1:0] enq_time,
   output logic [NUM_CORE-1:0]            ack,
   output logic [NUM_CORE-1:0]            ev_valid,
   output logic                           next_rnd,
   output logic                           running,
   output logic                           rtn_vld,
   output logic [phold_pkg::CNT_WID-1:0]  total_cycles,
   output logic [phold_pkg::CNT_WID-1:0]  total_events,
   output logic                           ev_sent,
   output logic [phold_pkg::LP_WID-1:0]   ev_sent_lp,
   output logic [phold_pkg::TIME_WID-1:0] ev_sent_time
);
   import phold_pkg::*;

   phold_state_e state;
   phold_state_e state_nxt;
   logic [7:0]   init_cnt;
   logic         queue_busy;
   logic         in_window;
   logic         enq_init;
   logic         enq_run;

   assign running = (state == RUNNING);
   // no new traffic once gvt has passed the end time
   assign in_window = running && (gvt <= sim_end);

   assign enq_init = (state == INIT) && !queue_busy && !q_full && (init_cnt < num_init_events);
   // returning events win over dispatch
   assign enq_run = in_window && !queue_busy && !q_full && rcv_gnt_vld;
   assign enq = enq_init || enq_run;
   assign deq = in_window && !queue_busy && !enq && !q_empty && send_gnt_vld;

   assign ack = enq_run ? rcv_gnt : '0;
   assign ev_valid = deq ? send_gnt : '0;
   assign next_rnd = deq || (state == INIT);

   // init events are time zero, LP is the index masked
   assign enq_lp = (state == INIT) ? (init_cnt[LP_WID-1:0] & lp_mask[LP_WID-1:0]) : new_lp;
   assign enq_time = (state == INIT) ? '0 : new_time;

   always_comb begin
      state_nxt = state;
      case (state)
         IDLE: state_nxt = INIT;
         INIT: begin
            if (init_cnt == num_init_events) begin
               state_nxt = READY;
            end
         end
         READY: state_nxt = RUNNING;
         RUNNING: begin
            if (gvt > sim_end) begin
               state_nxt = FINISHED;
            end
         end
         // finished holds until reset
         default: state_nxt = state;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= IDLE;
         init_cnt <= '0;
         queue_busy <= 1'b0;
         rtn_vld <= 1'b0;
         ev_sent <= 1'b0;
         total_cycles <= '0;
         total_events <= '0;
      end else begin
         state <= state_nxt;
         // queue needs a quiet cycle after every access
         queue_busy <= enq || deq;
         if (enq_init) begin
            init_cnt <= init_cnt + 8'd1;
         end
         rtn_vld <= running && (gvt > sim_end);
         ev_sent <= deq;
         if (running) begin
            total_cycles <= total_cycles + CNT_WID'(1);
         end
         if (deq) begin
            total_events <= total_events + CNT_WID'(1);
         end
      end
   end

   // dispatch trace payload
   always_ff @(posedge clk) begin
      if (deq) begin
         ev_sent_lp <= head_lp;
         ev_sent_time <= head_time;
      end
   end

endmodule

//--- source/gvt_tracker.sv
`timescale 1ns/1ps

module gvt_tracker #(
   parameter int NUM_CORE = 4
) (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    running,
   input  logic [phold_pkg::TIME_WID-1:0]          head_time,
   input  logic                                    q_empty,
   input  logic [NUM_CORE-1:0]                     core_busy,
   input  logic [NUM_CORE*phold_pkg::TIME_WID-1:0] core_time,
   output logic [phold_pkg::TIME_WID-1:0]          gvt
);
   import phold_pkg::*;

   logic [TIME_WID-1:0] min_time;
   logic                min_vld;

   // lowest pending time over queue head and busy cores
   always_comb begin
      min_time = head_time;
      min_vld = !q_empty;
      for (int i = 0; i < NUM_CORE; i++) begin
         if (core_busy[i] && (!min_vld || core_time[i*TIME_WID +: TIME_WID] < min_time)) begin
            min_time = core_time[i*TIME_WID +: TIME_WID];
            min_vld = 1'b1;
         end
      end
   end

   // only moves forward
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gvt <= '0;
      end else if (running && min_vld && (min_time >= gvt)) begin
         gvt <= min_time;
      end
   end

endmodule

//--- source/phold_core.sv
`timescale 1ns/1ps

module phold_core (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           ev_valid,
   input  logic                           ack,
   input  logic [phold_pkg::LP_WID-1:0]   ev_lp,
   input  logic [phold_pkg::TIME_WID-1:0] ev_time,
   input  logic [phold_pkg::RND_WID-1:0]  rnd,
   input  logic [phold_pkg::LP_WID-1:0]   lp_mask,
   output logic                           ready,
   output logic                           new_ready,
   output logic                           busy,
   output logic [phold_pkg::TIME_WID-1:0] busy_time,
   output logic [phold_pkg::TIME_WID-1:0] new_time,
   output logic [phold_pkg::LP_WID-1:0]   new_lp
);
   import phold_pkg::*;

   typedef enum logic [1:0] {
      CORE_IDLE,
      CORE_PROC,
      CORE_WAIT
   } core_state_e;

   core_state_e          state;
   logic [BUSY_WID-1:0]  delay;
   logic [DELTA_WID-1:0] delta;
   logic [LP_WID-1:0]    dest_lp;
   logic                 capture;

   assign capture = ev_valid && (state == CORE_IDLE);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= CORE_IDLE;
         delay <= '0;
      end else begin
         case (state)
            CORE_IDLE: begin
               if (capture) begin
                  state <= CORE_PROC;
                  delay <= rnd[BUSY_WID-1:0];
               end
            end
            // stays here delay+1 cycles
            CORE_PROC: begin
               if (delay == '0) begin
                  state <= CORE_WAIT;
               end else begin
                  delay <= delay - BUSY_WID'(1);
               end
            end
            CORE_WAIT: begin
               if (ack) begin
                  state <= CORE_IDLE;
               end
            end
            default: state <= CORE_IDLE;
         endcase
      end
   end

   // event payload and random fields taken on dispatch
   always_ff @(posedge clk) begin
      if (capture) begin
         busy_time <= ev_time;
         delta <= rnd[BUSY_WID +: DELTA_WID];
         // source LP folded in, cores capturing the same word still diverge
         dest_lp <= rnd[BUSY_WID+DELTA_WID +: LP_WID] ^ ev_lp;
      end
   end

   assign ready = (state == CORE_IDLE);
   assign new_ready = (state == CORE_WAIT);
   assign busy = (state != CORE_IDLE);

   // increment is 1..8 so new events are strictly later
   assign new_time = busy_time + TIME_WID'(delta) + TIME_WID'(1);
   assign new_lp = dest_lp & lp_mask;

endmodule

//--- source/event_queue.sv
`timescale 1ns/1ps

module event_queue #(
   parameter int QUEUE_DEPTH = 16
) (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           enq,
   input  logic                           deq,
   input  logic [phold_pkg::LP_WID-1:0]   in_lp,
   input  logic [phold_pkg::TIME_WID-1:0] in_time,
   output logic [phold_pkg::LP_WID-1:0]   head_lp,
   output logic [phold_pkg::TIME_WID-1:0] head_time,
   output logic                           full,
   output logic                           empty
);
   import phold_pkg::*;

   localparam int FILL_WID = $clog2(QUEUE_DEPTH + 1);

   logic [LP_WID-1:0]      lp_q [QUEUE_DEPTH];
   logic [TIME_WID-1:0]    time_q [QUEUE_DEPTH];
   logic [FILL_WID-1:0]    fill;
   logic [QUEUE_DEPTH-1:0] larger;
   logic                   do_enq;
   logic                   do_deq;

   assign full = (fill == FILL_WID'(QUEUE_DEPTH));
   assign empty = (fill == '0);
   assign do_enq = enq && !full;
   assign do_deq = deq && !empty;

   // smallest timestamp always sits in slot 0
   assign head_lp = lp_q[0];
   assign head_time = time_q[0];

   // empty slots count as larger, so the vector is a thermometer
   always_comb begin
      for (int i = 0; i < QUEUE_DEPTH; i++) begin
         larger[i] = (i >= int'(fill)) || (time_q[i] > in_time);
      end
   end

   // equal keys are not larger, new entry lands behind them
   always_ff @(posedge clk) begin
      if (do_enq) begin
         if (larger[0]) begin
            lp_q[0] <= in_lp;
            time_q[0] <= in_time;
         end
         for (int i = 1; i < QUEUE_DEPTH; i++) begin
            if (larger[i-1]) begin
               lp_q[i] <= lp_q[i-1];
               time_q[i] <= time_q[i-1];
            end else if (larger[i]) begin
               lp_q[i] <= in_lp;
               time_q[i] <= in_time;
            end
         end
      end else if (do_deq) begin
         for (int i = 0; i < QUEUE_DEPTH - 1; i++) begin
            lp_q[i] <= lp_q[i+1];
            time_q[i] <= time_q[i+1];
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fill <= '0;
      end else if (do_enq) begin
         fill <= fill + FILL_WID'(1);
      end else if (do_deq) begin
         fill <= fill - FILL_WID'(1);
      end
   end

endmodule

//--- source/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
   parameter int NUM_CORE = 4
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [NUM_CORE-1:0] req,
   output logic [NUM_CORE-1:0] gnt,
   output logic                gnt_vld
);
   localparam int IDX_WID = $clog2(NUM_CORE);

   logic [IDX_WID-1:0] last;
   logic [IDX_WID-1:0] win;

   assign gnt_vld = |req;

   // search starts one past the previous winner
   always_comb begin
      int  idx;
      logic found;
      gnt = '0;
      win = last;
      found = 1'b0;
      for (int i = 1; i <= NUM_CORE; i++) begin
         idx = (int'(last) + i) % NUM_CORE;
         if (!found && req[idx]) begin
            gnt[idx] = 1'b1;
            win = idx[IDX_WID-1:0];
            found = 1'b1;
         end
      end
   end

   // start with core 0 at top priority
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         last <= IDX_WID'(NUM_CORE - 1);
      end else if (gnt_vld) begin
         last <= win;
      end
   end

endmodule

//--- source/lfsr.sv
`timescale 1ns/1ps

module lfsr #(
   parameter logic [phold_pkg::RND_WID-1:0] SEED = phold_pkg::LFSR_SEED
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          next,
   output logic [phold_pkg::RND_WID-1:0] rnd
);
   import phold_pkg::*;

   // x^24 + x^23 + x^22 + x^17 + 1, maximal length
   localparam logic [RND_WID-1:0] TAPS = 24'he10000;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rnd <= SEED;
      end else if (next) begin
         rnd <= {1'b0, rnd[RND_WID-1:1]} ^ (rnd[0] ? TAPS : '0);
      end
   end

endmodule

//--- source/phold_pkg.sv
package phold_pkg;

   // datapath widths
   localparam int TIME_WID = 16;
   localparam int LP_WID = 6;
   localparam int CNT_WID = 64;

   // random word and the fields cut from it
   localparam int RND_WID = 24;
   localparam int DELTA_WID = 3;
   localparam int BUSY_WID = 2;

   // nonzero, the LFSR locks up on an all-zero state
   localparam logic [RND_WID-1:0] LFSR_SEED = 24'h5a3c91;

   // default sizes, overridable at phold_top
   localparam int DEF_NUM_CORE = 4;
   localparam int DEF_QUEUE_DEPTH = 16;

   // run controller states
   typedef enum logic [2:0] {
      IDLE     = 3'd0,
      INIT     = 3'd1,
      READY    = 3'd2,
      RUNNING  = 3'd3,
      FINISHED = 3'd4
   } phold_state_e;

endpackage
